/* Bender.yml */
package:
  name: axi_mem_slave

sources:
  - axi_mem_pkg.sv
  - axi_cmd_fifo.sv
  - axi_burst_addr.sv
  - axi_mem_store.sv
  - axi_mem_ctrl.sv
  - axi_mem_slave.sv
  - target: test
    files:
      - tb_clock.sv
      - axi_mem_slave_properties.sv
      - axi_mem_slave_tb.sv

/* axi_burst_addr.sv */
`timescale 1ns/1ps

module axi_burst_addr import axi_mem_pkg::*; (
    input  logic              aclk,
    input  logic              rstn,
    input  logic              load,
    input  axi_cmd_t          cmd,
    input  logic              step,
    output logic [addr_w-1:0] addr,
    output logic              illegal
);

    logic [len_w-1:0]  len_q;
    logic [size_w-1:0] size_q;
    burst_e            burst_q;
    logic [addr_w-1:0] beat_bytes;
    logic [addr_w-1:0] wrap_mask;
    logic [addr_w-1:0] next_addr;
    logic              wrap_bad;
    logic              cmd_bad;

    assign beat_bytes = addr_w'(1) << size_q;
    // window of (len+1) beats, aligned to its own size
    assign wrap_mask  = ((addr_w'(len_q) + addr_w'(1)) << size_q) - addr_w'(1);

    always_comb begin
        case (burst_q)
            burst_incr: next_addr = addr + beat_bytes;
            burst_wrap: next_addr = (addr & ~wrap_mask) | ((addr + beat_bytes) & wrap_mask);
            default:    next_addr = addr;
        endcase
    end

    // legality of the incoming command
    assign wrap_bad = (cmd.burst == burst_wrap) &&
                      !(cmd.len inside {len_w'(1), len_w'(3), len_w'(7), len_w'(15)});
    assign cmd_bad  = wrap_bad || (cmd.size > size_w'(lane_w)) || (cmd.burst == burst_rsvd);

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            illegal <= 1'b0;
        end else if (load) begin
            illegal <= cmd_bad;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            addr    <= cmd.addr;
            len_q   <= cmd.len;
            size_q  <= cmd.size;
            burst_q <= cmd.burst;
        end else if (step) begin
            addr <= next_addr;
        end
    end

endmodule

/* axi_cmd_fifo.sv */
`timescale 1ns/1ps

module axi_cmd_fifo import axi_mem_pkg::*; (
    input  logic     aclk,
    input  logic     rstn,
    input  logic     push,
    input  axi_cmd_t push_cmd,
    input  logic     pop,
    output axi_cmd_t head,
    output logic     empty,
    output logic     full
);

    axi_cmd_t           entries [cmd_depth];
    logic [cmd_ptr_w:0] wptr;
    logic [cmd_ptr_w:0] rptr;
    logic               ptr_full;
    logic               alive;
    logic               do_push;
    logic               do_pop;

    // extra msb tells full from empty
    assign ptr_full = (wptr[cmd_ptr_w] != rptr[cmd_ptr_w]) &&
                      (wptr[cmd_ptr_w-1:0] == rptr[cmd_ptr_w-1:0]);

    // reads as full until the first edge after reset
    assign full    = ptr_full || !alive;
    assign empty   = (wptr == rptr);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = entries[rptr[cmd_ptr_w-1:0]];

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            wptr  <= '0;
            rptr  <= '0;
            alive <= 1'b0;
        end else begin
            alive <= 1'b1;
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            entries[wptr[cmd_ptr_w-1:0]] <= push_cmd;
        end
    end

endmodule

/* axi_mem_ctrl.sv */
`timescale 1ns/1ps

module axi_mem_ctrl import axi_mem_pkg::*; (
    input  logic            aclk,
    input  logic            rstn,
    input  axi_cmd_t        aw_head,
    input  logic            aw_empty,
    input  logic            wvalid,
    input  logic            wlast,
    input  logic            bready,
    input  logic            w_illegal,
    input  axi_cmd_t        ar_head,
    input  logic            ar_empty,
    input  logic            rready,
    input  logic            r_illegal,
    output logic            aw_pop,
    output logic            wready,
    output logic            bvalid,
    output logic [id_w-1:0] bid,
    output resp_e           bresp,
    output logic            w_load,
    output logic            w_step,
    output logic            mem_we,
    output logic            ar_pop,
    output logic            rvalid,
    output logic            rlast,
    output logic [id_w-1:0] rid,
    output resp_e           rresp,
    output logic            r_load,
    output logic            r_step,
    output logic            mem_re
);

    wr_state_e        wr_state;
    wr_state_e        wr_next;
    rd_state_e        rd_state;
    rd_state_e        rd_next;
    logic [len_w-1:0] beat_cnt;
    logic             w_hs;
    logic             r_hs;

    // ******************************
    // write side
    // ******************************
    assign wready = (wr_state == wr_data);
    assign bvalid = (wr_state == wr_resp);
    assign w_hs   = wvalid && wready;
    assign w_load = (wr_state == wr_idle) && !aw_empty;
    assign w_step = w_hs;
    // illegal bursts drain W without touching memory
    assign mem_we = w_hs && !w_illegal;
    assign aw_pop = bvalid && bready;
    assign bid    = aw_head.id;
    assign bresp  = w_illegal ? resp_slverr : resp_okay;

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            wr_idle: begin
                if (!aw_empty) begin
                    wr_next = wr_data;
                end
            end
            wr_data: begin
                if (w_hs && wlast) begin
                    wr_next = wr_resp;
                end
            end
            wr_resp: begin
                if (bready) begin
                    wr_next = wr_idle;
                end
            end
            default: wr_next = wr_idle;
        endcase
    end

    // ******************************
    // read side
    // ******************************
    assign r_load = (rd_state == rd_idle) && !ar_empty;
    assign mem_re = (rd_state == rd_fetch);
    assign rvalid = (rd_state == rd_beat);
    assign rlast  = rvalid && (beat_cnt == ar_head.len);
    assign r_hs   = rvalid && rready;
    assign r_step = r_hs;
    assign ar_pop = r_hs && rlast;
    assign rid    = ar_head.id;
    assign rresp  = r_illegal ? resp_slverr : resp_okay;

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            rd_idle: begin
                if (!ar_empty) begin
                    rd_next = rd_fetch;
                end
            end
            rd_fetch: rd_next = rd_beat;
            rd_beat: begin
                if (r_hs) begin
                    rd_next = rlast ? rd_idle : rd_fetch;
                end
            end
            default: rd_next = rd_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            wr_state <= wr_idle;
            rd_state <= rd_idle;
            beat_cnt <= '0;
        end else begin
            wr_state <= wr_next;
            rd_state <= rd_next;
            // beats already handed over in this read burst
            if (r_load) begin
                beat_cnt <= '0;
            end else if (r_step) begin
                beat_cnt <= beat_cnt + len_w'(1);
            end
        end
    end

endmodule

/* axi_mem_pkg.sv */
package axi_mem_pkg;

    // ******************************
    // bus and memory geometry
    // ******************************
    localparam int id_w      = 4;
    localparam int addr_w    = 16;
    localparam int len_w     = 8;
    localparam int size_w    = 3;
    localparam int data_w    = 32;
    localparam int strb_w    = data_w / 8;
    localparam int lane_w    = $clog2(strb_w);
    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);
    localparam int cmd_depth = 4;
    localparam int cmd_ptr_w = $clog2(cmd_depth);

    // ******************************
    // AXI encodings
    // ******************************
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10,
        burst_rsvd  = 2'b11
    } burst_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

    // one queued address command, AW or AR
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
        logic [size_w-1:0] size;
        burst_e            burst;
    } axi_cmd_t;

    // ******************************
    // controller states
    // ******************************
    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_e;

    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,
        rd_beat
    } rd_state_e;

endpackage

/* axi_mem_slave.f */
axi_mem_pkg.sv
axi_cmd_fifo.sv
axi_burst_addr.sv
axi_mem_store.sv
axi_mem_ctrl.sv
axi_mem_slave.sv
tb_clock.sv
axi_mem_slave_properties.sv
axi_mem_slave_tb.sv

/* axi_mem_slave.sv */
`timescale 1ns/1ps

module axi_mem_slave import axi_mem_pkg::*; (
    input  logic              aclk,
    input  logic              rstn,
    // write address
    input  logic [id_w-1:0]   awid,
    input  logic [addr_w-1:0] awaddr,
    input  logic [len_w-1:0]  awlen,
    input  logic [size_w-1:0] awsize,
    input  logic [1:0]        awburst,
    input  logic              awvalid,
    output logic              awready,
    // write data
    input  logic [data_w-1:0] wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic              wlast,
    input  logic              wvalid,
    output logic              wready,
    // write response
    output logic [id_w-1:0]   bid,
    output resp_e             bresp,
    output logic              bvalid,
    input  logic              bready,
    // read address
    input  logic [id_w-1:0]   arid,
    input  logic [addr_w-1:0] araddr,
    input  logic [len_w-1:0]  arlen,
    input  logic [size_w-1:0] arsize,
    input  logic [1:0]        arburst,
    input  logic              arvalid,
    output logic              arready,
    // read data
    output logic [id_w-1:0]   rid,
    output logic [data_w-1:0] rdata,
    output resp_e             rresp,
    output logic              rlast,
    output logic              rvalid,
    input  logic              rready
);

    axi_cmd_t          aw_cmd;
    axi_cmd_t          ar_cmd;
    axi_cmd_t          aw_head;
    axi_cmd_t          ar_head;
    logic              aw_empty;
    logic              aw_full;
    logic              ar_empty;
    logic              ar_full;
    logic              aw_pop;
    logic              ar_pop;
    logic              w_load;
    logic              w_step;
    logic              w_illegal;
    logic [addr_w-1:0] w_addr;
    logic              r_load;
    logic              r_step;
    logic              r_illegal;
    logic [addr_w-1:0] r_addr;
    logic              mem_we;
    logic              mem_re;

    assign aw_cmd  = '{id: awid, addr: awaddr, len: awlen, size: awsize,
                       burst: burst_e'(awburst)};
    assign ar_cmd  = '{id: arid, addr: araddr, len: arlen, size: arsize,
                       burst: burst_e'(arburst)};
    assign awready = !aw_full;
    assign arready = !ar_full;

    // ******************************
    // command queues
    // ******************************
    axi_cmd_fifo u_aw_fifo (
        .aclk     (aclk),
        .rstn     (rstn),
        .push     (awvalid && awready),
        .push_cmd (aw_cmd),
        .pop      (aw_pop),
        .head     (aw_head),
        .empty    (aw_empty),
        .full     (aw_full)
    );

    axi_cmd_fifo u_ar_fifo (
        .aclk     (aclk),
        .rstn     (rstn),
        .push     (arvalid && arready),
        .push_cmd (ar_cmd),
        .pop      (ar_pop),
        .head     (ar_head),
        .empty    (ar_empty),
        .full     (ar_full)
    );

    // ******************************
    // beat addresses
    // ******************************
    axi_burst_addr u_w_addr (
        .aclk    (aclk),
        .rstn    (rstn),
        .load    (w_load),
        .cmd     (aw_head),
        .step    (w_step),
        .addr    (w_addr),
        .illegal (w_illegal)
    );

    axi_burst_addr u_r_addr (
        .aclk    (aclk),
        .rstn    (rstn),
        .load    (r_load),
        .cmd     (ar_head),
        .step    (r_step),
        .addr    (r_addr),
        .illegal (r_illegal)
    );

    axi_mem_store u_mem (
        .aclk  (aclk),
        .we    (mem_we),
        .waddr (w_addr),
        .wdata (wdata),
        .wstrb (wstrb),
        .re    (mem_re),
        .raddr (r_addr),
        .rdata (rdata)
    );

    axi_mem_ctrl u_ctrl (
        .aclk      (aclk),
        .rstn      (rstn),
        .aw_head   (aw_head),
        .aw_empty  (aw_empty),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .bready    (bready),
        .w_illegal (w_illegal),
        .ar_head   (ar_head),
        .ar_empty  (ar_empty),
        .rready    (rready),
        .r_illegal (r_illegal),
        .aw_pop    (aw_pop),
        .wready    (wready),
        .bvalid    (bvalid),
        .bid       (bid),
        .bresp     (bresp),
        .w_load    (w_load),
        .w_step    (w_step),
        .mem_we    (mem_we),
        .ar_pop    (ar_pop),
        .rvalid    (rvalid),
        .rlast     (rlast),
        .rid       (rid),
        .rresp     (rresp),
        .r_load    (r_load),
        .r_step    (r_step),
        .mem_re    (mem_re)
    );

endmodule

/* axi_mem_slave_properties.sv */
`timescale 1ns/1ps

module axi_mem_slave_properties import axi_mem_pkg::*; (
    input logic              aclk,
    input logic              rstn,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic              bvalid,
    input logic              bready,
    input logic              arvalid,
    input logic              arready,
    input logic              rvalid,
    input logic              rready,
    input logic [data_w-1:0] rdata,
    input wr_state_e         wr_state,
    input rd_state_e         rd_state
);

    int fail_count = 0;

    // ******************************
    // valid held until ready
    // ******************************
    aw_valid_held: assert property (@(posedge aclk) disable iff (!rstn)
        awvalid && !awready |=> awvalid)
        else begin
            fail_count++;
            $error("awvalid dropped before awready");
        end

    w_valid_held: assert property (@(posedge aclk) disable iff (!rstn)
        wvalid && !wready |=> wvalid)
        else begin
            fail_count++;
            $error("wvalid dropped before wready");
        end

    b_valid_held: assert property (@(posedge aclk) disable iff (!rstn)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    ar_valid_held: assert property (@(posedge aclk) disable iff (!rstn)
        arvalid && !arready |=> arvalid)
        else begin
            fail_count++;
            $error("arvalid dropped before arready");
        end

    r_valid_held: assert property (@(posedge aclk) disable iff (!rstn)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    r_data_stable: assert property (@(posedge aclk) disable iff (!rstn)
        rvalid && !rready |=> $stable(rdata))
        else begin
            fail_count++;
            $error("rdata changed while stalled");
        end

    // responses quiet in reset
    quiet_in_reset: assert property (@(posedge aclk)
        !rstn |-> !bvalid && !rvalid)
        else begin
            fail_count++;
            $error("response valid during reset");
        end

    wr_state_legal: assert property (@(posedge aclk) disable iff (!rstn)
        wr_state inside {wr_idle, wr_data, wr_resp})
        else begin
            fail_count++;
            $error("write FSM left its states");
        end

    rd_state_legal: assert property (@(posedge aclk) disable iff (!rstn)
        rd_state inside {rd_idle, rd_fetch, rd_beat})
        else begin
            fail_count++;
            $error("read FSM left its states");
        end

endmodule

bind axi_mem_slave axi_mem_slave_properties u_props (
    .aclk     (aclk),
    .rstn     (rstn),
    .awvalid  (awvalid),
    .awready  (awready),
    .wvalid   (wvalid),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready),
    .arvalid  (arvalid),
    .arready  (arready),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .wr_state (u_ctrl.wr_state),
    .rd_state (u_ctrl.rd_state)
);

/* axi_mem_slave_tb.sv */
`timescale 1ns/1ps

module axi_mem_slave_tb import axi_mem_pkg::*; ();

    logic              aclk;
    logic              rstn;
    logic [id_w-1:0]   awid;
    logic [addr_w-1:0] awaddr;
    logic [len_w-1:0]  awlen;
    logic [size_w-1:0] awsize;
    logic [1:0]        awburst;
    logic              awvalid;
    logic              awready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic [id_w-1:0]   bid;
    resp_e             bresp;
    logic              bvalid;
    logic              bready;
    logic [id_w-1:0]   arid;
    logic [addr_w-1:0] araddr;
    logic [len_w-1:0]  arlen;
    logic [size_w-1:0] arsize;
    logic [1:0]        arburst;
    logic              arvalid;
    logic              arready;
    logic [id_w-1:0]   rid;
    logic [data_w-1:0] rdata;
    resp_e             rresp;
    logic              rlast;
    logic              rvalid;
    logic              rready;

    logic [7:0]        ref_mem [mem_words*strb_w];
    logic [strb_w-1:0] strb_plan [16];
    int                seed;

    tb_clock u_clock (
        .aclk (aclk),
        .rstn (rstn)
    );

    axi_mem_slave UUT (.*);

    // ******************************
    // reference model
    // ******************************
    function automatic axi_cmd_t make_cmd(logic [id_w-1:0] cid, logic [addr_w-1:0] caddr,
                                          logic [len_w-1:0] clen, logic [size_w-1:0] csize,
                                          burst_e cburst);
        make_cmd = '{id: cid, addr: caddr, len: clen, size: csize, burst: cburst};
    endfunction

    function automatic bit is_legal(axi_cmd_t cmd);
        if (cmd.size > 2 || cmd.burst == burst_rsvd) begin
            return 1'b0;
        end
        if (cmd.burst == burst_wrap) begin
            return (cmd.len + 1) inside {2, 4, 8, 16};
        end
        return 1'b1;
    endfunction

    // byte address of one beat
    function automatic logic [addr_w-1:0] beat_address(axi_cmd_t cmd, int beat);
        int nbytes;
        int window;
        int base;
        nbytes = 1 << cmd.size;
        case (cmd.burst)
            burst_fixed: beat_address = cmd.addr;
            burst_wrap: begin
                window = nbytes * (cmd.len + 1);
                base = cmd.addr - (cmd.addr % window);
                beat_address = base + ((cmd.addr - base + beat * nbytes) % window);
            end
            default: beat_address = cmd.addr + beat * nbytes;
        endcase
    endfunction

    function automatic int word_of(logic [addr_w-1:0] addr);
        return (addr / strb_w) % mem_words;
    endfunction

    function automatic void model_write(axi_cmd_t cmd, int beat, logic [data_w-1:0] data,
                                        logic [strb_w-1:0] strb);
        int word;
        word = word_of(beat_address(cmd, beat));
        for (int i = 0; i < strb_w; i++) begin
            if (strb[i]) begin
                ref_mem[word*strb_w + i] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [data_w-1:0] model_read(axi_cmd_t cmd, int beat);
        int word;
        word = word_of(beat_address(cmd, beat));
        for (int i = 0; i < strb_w; i++) begin
            model_read[8*i +: 8] = ref_mem[word*strb_w + i];
        end
    endfunction

    function automatic int random_stall(int max_stall);
        if (max_stall == 0) begin
            return 0;
        end
        return $unsigned($random(seed)) % (max_stall + 1);
    endfunction

    // ******************************
    // checks and waits
    // ******************************
    task automatic stop_run(string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string test, string field, logic [data_w-1:0] exp,
                               logic [data_w-1:0] act);
        assert (act === exp) else begin
            stop_run($sformatf("Error: %s %s expected 0x%0h actual 0x%0h",
                               test, field, exp, act));
        end
    endtask

    // one cycle, limited to 200 per wait
    task automatic advance_or_stop(inout int cnt, input string what);
        @(negedge aclk);
        cnt++;
        if (cnt > 200) begin
            stop_run($sformatf("timeout while waiting for %s", what));
        end
    endtask

    // a failed bound property ends the run at once
    always @(negedge aclk) begin
        if (UUT.u_props.fail_count != 0) begin
            stop_run("a bound protocol property failed");
        end
    end

    function automatic void fill_strobes(logic [strb_w-1:0] strb);
        for (int i = 0; i < 16; i++) begin
            strb_plan[i] = strb;
        end
    endfunction

    // ******************************
    // channel drivers, entered at a falling edge
    // ******************************
    task automatic send_addr_write(axi_cmd_t cmd);
        int cnt;
        awid    = cmd.id;
        awaddr  = cmd.addr;
        awlen   = cmd.len;
        awsize  = cmd.size;
        awburst = cmd.burst;
        awvalid = 1'b1;
        cnt = 0;
        while (!awready) begin
            advance_or_stop(cnt, "awready");
        end
        @(negedge aclk);
        awvalid = 1'b0;
    endtask

    task automatic send_addr_read(axi_cmd_t cmd);
        int cnt;
        arid    = cmd.id;
        araddr  = cmd.addr;
        arlen   = cmd.len;
        arsize  = cmd.size;
        arburst = cmd.burst;
        arvalid = 1'b1;
        cnt = 0;
        while (!arready) begin
            advance_or_stop(cnt, "arready");
        end
        @(negedge aclk);
        arvalid = 1'b0;
    endtask

    task automatic send_write_data(axi_cmd_t cmd);
        logic [data_w-1:0] data;
        int                cnt;
        bit                legal;
        legal = is_legal(cmd);
        for (int beat = 0; beat <= cmd.len; beat++) begin
            data   = $random(seed);
            wdata  = data;
            wstrb  = strb_plan[beat];
            wlast  = (beat == cmd.len);
            wvalid = 1'b1;
            cnt = 0;
            while (!wready) begin
                advance_or_stop(cnt, "wready");
            end
            // refused bursts leave memory alone
            if (legal) begin
                model_write(cmd, beat, data, strb_plan[beat]);
            end
            @(negedge aclk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic collect_write_resp(string test, axi_cmd_t cmd, int max_stall);
        int cnt;
        cnt = 0;
        while (!bvalid) begin
            advance_or_stop(cnt, "bvalid");
        end
        repeat (random_stall(max_stall)) @(negedge aclk);
        check_value(test, "bid", cmd.id, bid);
        check_value(test, "bresp", is_legal(cmd) ? resp_okay : resp_slverr, bresp);
        bready = 1'b1;
        @(negedge aclk);
        bready = 1'b0;
    endtask

    task automatic collect_read(string test, axi_cmd_t cmd, int max_stall);
        int cnt;
        bit legal;
        legal = is_legal(cmd);
        for (int beat = 0; beat <= cmd.len; beat++) begin
            cnt = 0;
            while (!rvalid) begin
                advance_or_stop(cnt, "rvalid");
            end
            repeat (random_stall(max_stall)) @(negedge aclk);
            check_value(test, "rid", cmd.id, rid);
            check_value(test, "rresp", legal ? resp_okay : resp_slverr, rresp);
            check_value(test, "rlast", beat == cmd.len, rlast);
            if (legal) begin
                check_value(test, "rdata", model_read(cmd, beat), rdata);
            end
            rready = 1'b1;
            @(negedge aclk);
            rready = 1'b0;
        end
    endtask

    task automatic write_burst(string test, axi_cmd_t cmd, int max_stall);
        send_addr_write(cmd);
        send_write_data(cmd);
        collect_write_resp(test, cmd, max_stall);
    endtask

    task automatic read_burst(string test, axi_cmd_t cmd, int max_stall);
        send_addr_read(cmd);
        collect_read(test, cmd, max_stall);
    endtask

    // ******************************
    // test sequence
    // ******************************
    initial begin
        axi_cmd_t wr_cmds [4];
        axi_cmd_t rd_cmds [4];
        int       cnt;
        seed    = 67619;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        fill_strobes('1);
        cnt = 0;
        while (rstn !== 1'b1) begin
            advance_or_stop(cnt, "reset release");
        end
        @(negedge aclk);

        // incr round trip
        write_burst("incr", make_cmd(4'h3, 16'h0040, 7, 2, burst_incr), 0);
        read_burst("incr", make_cmd(4'h5, 16'h0040, 7, 2, burst_incr), 0);

        // wrap from the middle of a 16 byte window
        write_burst("wrap", make_cmd(4'h1, 16'h0108, 3, 2, burst_wrap), 0);
        read_burst("wrap", make_cmd(4'h2, 16'h0108, 3, 2, burst_wrap), 0);
        read_burst("wrap", make_cmd(4'h2, 16'h0100, 3, 2, burst_incr), 0);

        // fixed burst, partial strobes on one word
        strb_plan[0] = 4'b1111;
        strb_plan[1] = 4'b0101;
        strb_plan[2] = 4'b0011;
        strb_plan[3] = 4'b1000;
        strb_plan[4] = 4'b0100;
        write_burst("fixed", make_cmd(4'h6, 16'h0200, 4, 2, burst_fixed), 0);
        fill_strobes('1);
        read_burst("fixed", make_cmd(4'h7, 16'h0200, 0, 2, burst_incr), 0);

        // refused bursts
        write_burst("illegal", make_cmd(4'h9, 16'h0300, 3, 2, burst_incr), 0);
        write_burst("illegal", make_cmd(4'ha, 16'h0300, 2, 2, burst_wrap), 0);
        read_burst("illegal", make_cmd(4'hb, 16'h0300, 3, 2, burst_incr), 0);
        read_burst("illegal", make_cmd(4'hc, 16'h0300, 2, 2, burst_wrap), 0);
        read_burst("illegal", make_cmd(4'hd, 16'h0300, 1, 3, burst_incr), 0);

        // several commands queued ahead of data, with back-pressure
        for (int i = 0; i < 4; i++) begin
            wr_cmds[i] = make_cmd(id_w'(8 + i), addr_w'(16'h0400 + 64 * i),
                                  len_w'(i + 1), 2, burst_incr);
            send_addr_write(wr_cmds[i]);
        end
        for (int i = 0; i < 4; i++) begin
            send_write_data(wr_cmds[i]);
            collect_write_resp("queue", wr_cmds[i], 5);
        end
        for (int i = 0; i < 4; i++) begin
            rd_cmds[i] = make_cmd(id_w'(12 + i), wr_cmds[i].addr, wr_cmds[i].len, 2,
                                  burst_incr);
            send_addr_read(rd_cmds[i]);
        end
        for (int i = 0; i < 4; i++) begin
            collect_read("queue", rd_cmds[i], 5);
        end

        repeat (2) @(negedge aclk);
        if (UUT.u_props.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

/* axi_mem_store.sv */
`timescale 1ns/1ps

module axi_mem_store import axi_mem_pkg::*; (
    input  logic              aclk,
    input  logic              we,
    input  logic [addr_w-1:0] waddr,
    input  logic [data_w-1:0] wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic              re,
    input  logic [addr_w-1:0] raddr,
    output logic [data_w-1:0] rdata
);

    logic [strb_w-1:0][7:0] mem [mem_words];
    logic [mem_aw-1:0]      widx;
    logic [mem_aw-1:0]      ridx;

    // word index, upper address bits dropped
    assign widx = waddr[lane_w +: mem_aw];
    assign ridx = raddr[lane_w +: mem_aw];

    always_ff @(posedge aclk) begin
        if (we) begin
            for (int i = 0; i < strb_w; i++) begin
                if (wstrb[i]) begin
                    mem[widx][i] <= wdata[8*i +: 8];
                end
            end
        end
        // same-cycle write is not seen here
        if (re) begin
            rdata <= mem[ridx];
        end
    end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic aclk,
    output logic rstn
);

    // 100 ns period
    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // reset held over 5 rising edges
    initial begin
        rstn <= 1'b0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rstn = 1'b1;
    end

endmodule
